/* Makefile */
# Verilator build for the 32X PWM unit

VERILATOR  ?= verilator
TOP        ?= tbS32xPwm
RTL_TOP    ?= s32xPwmIf
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert
PASS_TEXT  ?= NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
common/s32xBusPkg.sv
common/s32xPwmPkg.sv
pwm/pwmRegs.sv
pwm/pwmTimer.sv
pwm/pwmWidthFifo.sv
src/mdRegBus.sv
src/s32xPwmIf.sv
tests/s32xPwmAssert.sv
tests/tbS32xPwm.sv

/* common/s32xBusPkg.sv */
`default_nettype none

package s32xBusPkg;

	// Page A15100 to A1517F, compared against va[23:7]
	localparam logic [16:0] sysPageBase = 17'(24'hA15100 >> 7);

	typedef logic [5:0] regOffset_t;   // Byte offset inside the page
	typedef logic [15:0] busWord_t;

	// One decoded 68000 access, valid for a single clock
	typedef struct packed {
		logic       wrLo;
		logic       wrHi;
		logic       rd;
		regOffset_t offset;
		busWord_t   data;
	} regAccess_t;

	localparam regOffset_t offPwmCtrl    = 6'h30;
	localparam regOffset_t offCycle      = 6'h32;
	localparam regOffset_t offLeftWidth  = 6'h34;
	localparam regOffset_t offRightWidth = 6'h36;
	localparam regOffset_t offMonoWidth  = 6'h38;

endpackage

`default_nettype wire

/* common/s32xPwmPkg.sv */
`default_nettype none

package s32xPwmPkg;

	// PWMCR layout
	typedef struct packed {
		logic [3:0] rsvHi;
		logic [3:0] tm;     // Timer interval in cycle ends
		logic       rtp;    // DMA request enable
		logic [2:0] rsvLo;
		logic [1:0] rmd;
		logic [1:0] lmd;
	} pwmCtrl_t;

	localparam logic [15:0] pwmCtrlMask  = 16'h0F8F;
	localparam logic [15:0] cycleMask    = 16'h0FFF;
	localparam logic [15:0] widthMask    = 16'h0FFF;
	localparam int          fifoDepth    = 3;
	localparam logic [11:0] sampleCenter = 12'h800;

	// Same register word, written as a width and read back as queue status
	typedef union packed {
		struct packed {
			logic [3:0]  rsv;
			logic [11:0] pw;
		} width;
		struct packed {
			logic        full;
			logic        empty;
			logic [13:0] rsv;
		} status;
	} pwmWidth_u;

	typedef struct packed {
		logic        valid;
		logic [11:0] pw;
	} widthPush_t;

	typedef struct packed {
		logic full;
		logic empty;
	} fifoStatus_t;

endpackage

`default_nettype wire

/* pwm/pwmRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module pwmRegs import s32xBusPkg::*, s32xPwmPkg::*; (
	input  wire              CLK,
	input  wire              RST_N,
	input  wire  regAccess_t access,
	input  wire fifoStatus_t leftStatus,
	input  wire fifoStatus_t rightStatus,
	output busWord_t         readData,
	output pwmCtrl_t         pwmCtrl,
	output logic      [11:0] cycle,
	output widthPush_t       leftPush,
	output widthPush_t       rightPush
);
	pwmWidth_u leftWord;
	pwmWidth_u rightWord;
	pwmWidth_u leftNext;
	pwmWidth_u rightNext;
	logic      wrAny;
	logic      wrLeft;
	logic      wrRight;

	// Byte lanes of the write merged into the held width
	function automatic pwmWidth_u mergeLanes(pwmWidth_u held, regAccess_t acc);
		logic [15:0] merged;
		merged = held;
		if (acc.wrLo) merged[7:0] = acc.data[7:0];
		if (acc.wrHi) merged[15:8] = acc.data[15:8];
		return pwmWidth_u'(merged & widthMask);
	endfunction

	function automatic busWord_t statusWord(fifoStatus_t st);
		pwmWidth_u word;
		word = '0;
		word.status.full  = st.full;
		word.status.empty = st.empty;
		return word;
	endfunction

	assign wrAny     = access.wrLo || access.wrHi;
	assign wrLeft    = wrAny && (access.offset == offLeftWidth || access.offset == offMonoWidth);
	assign wrRight   = wrAny && (access.offset == offRightWidth || access.offset == offMonoWidth);
	assign leftNext  = mergeLanes(leftWord, access);
	assign rightNext = mergeLanes(rightWord, access);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pwmCtrl   <= '0;
			cycle     <= '0;
			leftWord  <= '0;
			rightWord <= '0;
			leftPush  <= '0;
			rightPush <= '0;
		end else begin
			leftPush.valid  <= wrLeft;
			leftPush.pw     <= leftNext.width.pw;
			rightPush.valid <= wrRight;
			rightPush.pw    <= rightNext.width.pw;
			if (wrLeft) leftWord <= leftNext;
			if (wrRight) rightWord <= rightNext;

			// 68000 side only reaches the low byte of PWMCR
			if (access.wrLo && access.offset == offPwmCtrl)
				pwmCtrl[7:0] <= access.data[7:0] & pwmCtrlMask[7:0];

			if (access.offset == offCycle) begin
				if (access.wrLo) cycle[7:0] <= access.data[7:0] & cycleMask[7:0];
				if (access.wrHi) cycle[11:8] <= access.data[11:8] & cycleMask[11:8];
			end
		end
	end

	always_comb begin
		case (access.offset)
			offPwmCtrl:    readData = pwmCtrl & pwmCtrlMask;
			offCycle:      readData = 16'(cycle) & cycleMask;
			offLeftWidth,
			offMonoWidth:  readData = statusWord(leftStatus);   // Mono shows the left queue
			offRightWidth: readData = statusWord(rightStatus);
			default:       readData = '0;
		endcase
	end

endmodule

`default_nettype wire

/* pwm/pwmTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module pwmTimer import s32xPwmPkg::*; (
	input  wire           CLK,
	input  wire           RST_N,
	input  wire           tickEn,
	input  wire pwmCtrl_t pwmCtrl,
	input  wire    [11:0] cycle,
	output logic          cycleEnd,
	output logic          pwmDreq
);
	logic        running;
	logic [11:0] cycCnt;
	logic [11:0] cycNext;
	logic  [3:0] timeCnt;
	logic  [3:0] timeNext;
	logic        timerHit;
	logic        reqPend;

	assign running  = |pwmCtrl.lmd || |pwmCtrl.rmd;
	assign cycNext  = cycCnt + 12'd1;
	assign timeNext = timeCnt + 4'd1;
	assign cycleEnd = tickEn && running && (cycNext == cycle);
	assign timerHit = cycleEnd && (timeNext == pwmCtrl.tm);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cycCnt  <= '0;
			timeCnt <= '0;
			reqPend <= 1'b0;
			pwmDreq <= 1'b0;
		end else begin
			if (!running) begin
				cycCnt  <= '0;
				timeCnt <= '0;
			end else if (cycleEnd) begin
				cycCnt  <= '0;
				timeCnt <= timerHit ? 4'd0 : timeNext;
			end else if (tickEn) begin
				cycCnt <= cycNext;
			end

			// Request lasts one tickEn period
			if (tickEn) begin
				if (reqPend) begin
					pwmDreq <= pwmCtrl.rtp;   // RTP sampled as the request fires
					reqPend <= 1'b0;
				end else if (pwmDreq) begin
					pwmDreq <= 1'b0;
				end
			end
			if (timerHit) reqPend <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* pwm/pwmWidthFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module pwmWidthFifo import s32xPwmPkg::*; (
	input  wire             CLK,
	input  wire             RST_N,
	input  wire             tickEn,
	input  wire             cycleEnd,
	input  wire widthPush_t push,
	output fifoStatus_t     status,
	output logic     [15:0] sample
);
	logic [11:0] slots [fifoDepth];
	logic        pend;
	logic [11:0] pendPw;
	logic  [1:0] rdPtr;
	logic  [1:0] wrPtr;
	logic  [1:0] count;
	logic        doPush;
	logic        doPop;

	function automatic logic [1:0] nextPos(logic [1:0] pos);
		return (pos == 2'(fifoDepth - 1)) ? 2'd0 : pos + 2'd1;
	endfunction

	// Stores wait for a tick that is not a cycle end
	assign doPush = pend && tickEn && !cycleEnd;
	assign doPop  = cycleEnd;
	assign sample = {slots[rdPtr] - sampleCenter, 4'h0};

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			slots        <= '{default: '0};
			pend         <= 1'b0;
			pendPw       <= '0;
			rdPtr        <= '0;
			wrPtr        <= '0;
			count        <= '0;
			status.full  <= 1'b0;
			status.empty <= 1'b1;
		end else begin
			if (doPush) begin
				slots[wrPtr] <= pendPw;   // Overwrites when full
				wrPtr        <= nextPos(wrPtr);
				pend         <= 1'b0;
			end
			if (push.valid) begin
				pend   <= 1'b1;
				pendPw <= push.pw;
			end
			if (doPop) rdPtr <= nextPos(rdPtr);

			// Push and pop never share a cycle
			if (doPush) begin
				if (count == 2'(fifoDepth - 1)) status.full <= 1'b1;
				else count <= count + 2'd1;
				status.empty <= 1'b0;
			end else if (doPop) begin
				if (count == 2'd0) status.empty <= 1'b1;
				else count <= count - 2'd1;
				status.full <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* src/mdRegBus.sv */
`timescale 1ns/1ps
`default_nettype none

module mdRegBus import s32xBusPkg::*; (
	input  wire           CLK,
	input  wire           RST_N,
	input  wire    [23:1] va,
	input  wire    [15:0] vdi,
	input  wire           asN,
	input  wire           lwrN,
	input  wire           uwrN,
	input  wire           cas0N,
	input  wire busWord_t readData,
	output regAccess_t    access,
	output busWord_t      vdo,
	output logic          dtackN
);
	logic     pageSel;
	logic     lowHalf;
	logic     anyWr;
	logic     busStart;
	busWord_t rdReg;

	assign pageSel  = (va[23:7] == sysPageBase) && !asN;
	assign lowHalf  = !va[6];   // Registers sit below offset 40
	assign anyWr    = !lwrN || !uwrN;
	// dtackN low blocks a second access in the same bus cycle
	assign busStart = pageSel && dtackN && (anyWr || !cas0N);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			access <= '0;
			dtackN <= 1'b1;
		end else begin
			access.wrLo <= busStart && lowHalf && !lwrN;
			access.wrHi <= busStart && lowHalf && !uwrN;
			access.rd   <= busStart && lowHalf && !anyWr && !cas0N;   // Write wins over read
			if (busStart) begin
				access.offset <= {va[5:1], 1'b0};
				access.data   <= vdi;
				dtackN        <= 1'b0;
			end else if (asN && !dtackN) begin
				dtackN <= 1'b1;   // Released after the strobe ends
			end
		end
	end

	// Register read data arrives during the access pulse
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rdReg <= '0;
		end else if (busStart) begin
			rdReg <= '0;   // Upper half of the page reads zero
		end else if (access.rd) begin
			rdReg <= readData;
		end
	end

	assign vdo = pageSel ? rdReg : '0;

endmodule

`default_nettype wire

/* src/s32xPwmIf.sv */
`timescale 1ns/1ps
`default_nettype none

module s32xPwmIf import s32xBusPkg::*, s32xPwmPkg::*; (
	input  wire         CLK,
	input  wire         RST_N,
	input  wire         tickEn,
	input  wire  [23:1] va,
	input  wire  [15:0] vdi,
	output logic [15:0] vdo,
	input  wire         asN,
	input  wire         lwrN,
	input  wire         uwrN,
	input  wire         cas0N,
	output logic        dtackN,
	output logic [15:0] pwmL,
	output logic [15:0] pwmR,
	output logic        pwmDreq
);
	regAccess_t  access;
	busWord_t    readData;
	pwmCtrl_t    pwmCtrl;
	logic [11:0] cycle;
	widthPush_t  leftPush;
	widthPush_t  rightPush;
	fifoStatus_t leftStatus;
	fifoStatus_t rightStatus;
	logic        cycleEnd;

	mdRegBus busFront (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.va       (va),
		.vdi      (vdi),
		.asN      (asN),
		.lwrN     (lwrN),
		.uwrN     (uwrN),
		.cas0N    (cas0N),
		.readData (readData),
		.access   (access),
		.vdo      (vdo),
		.dtackN   (dtackN)
	);

	pwmRegs regs (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.access      (access),
		.leftStatus  (leftStatus),
		.rightStatus (rightStatus),
		.readData    (readData),
		.pwmCtrl     (pwmCtrl),
		.cycle       (cycle),
		.leftPush    (leftPush),
		.rightPush   (rightPush)
	);

	pwmTimer timer (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.tickEn   (tickEn),
		.pwmCtrl  (pwmCtrl),
		.cycle    (cycle),
		.cycleEnd (cycleEnd),
		.pwmDreq  (pwmDreq)
	);

	pwmWidthFifo leftFifo (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.tickEn   (tickEn),
		.cycleEnd (cycleEnd),
		.push     (leftPush),
		.status   (leftStatus),
		.sample   (pwmL)
	);

	pwmWidthFifo rightFifo (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.tickEn   (tickEn),
		.cycleEnd (cycleEnd),
		.push     (rightPush),
		.status   (rightStatus),
		.sample   (pwmR)
	);

endmodule

`default_nettype wire

/* tests/s32xPwmAssert.sv */
`timescale 1ns/1ps
`default_nettype none

module s32xPwmAssert (
	input wire CLK,
	input wire RST_N,
	input wire asN,
	input wire dtackN,
	input wire tickEn,
	input wire pwmDreq,
	input wire rtp
);

	// DTACK is released only once the address strobe has ended
	dtackAfterStrobe: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(dtackN) |-> $past(asN))
		else $error("dtackN rose while asN was still low");

	// Request ends at the second tick enable
	dreqLength: assert property (@(posedge CLK) disable iff (!RST_N)
		(pwmDreq && tickEn) |=> !pwmDreq)
		else $error("pwmDreq stayed high past its second tick enable");

	dreqNeedsRtp: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(pwmDreq) |-> $past(rtp))
		else $error("pwmDreq rose with RTP clear");

endmodule

bind s32xPwmIf s32xPwmAssert busChecks (
	.CLK     (CLK),
	.RST_N   (RST_N),
	.asN     (asN),
	.dtackN  (dtackN),
	.tickEn  (tickEn),
	.pwmDreq (pwmDreq),
	.rtp     (pwmCtrl.rtp)
);

`default_nettype wire

/* tests/tbS32xPwm.sv */
`timescale 1ns/1ps
`default_nettype none

module tbS32xPwm;
	localparam int busLimit  = 32;    // Clocks per bus phase
	localparam int tickLimit = 64;    // Clocks per tick enable
	localparam int pwmCycle  = 3;
	localparam int dreqTicks = 200;

	logic        CLK     = 1'b0;
	logic        RST_N   = 1'b0;
	logic        tickEn  = 1'b0;
	logic  [1:0] tickDiv = 2'd0;
	logic [23:1] va      = '0;
	logic [15:0] vdi     = '0;
	logic        asN     = 1'b1;
	logic        lwrN    = 1'b1;
	logic        uwrN    = 1'b1;
	logic        cas0N   = 1'b1;
	wire  [15:0] vdo;
	wire         dtackN;
	wire  [15:0] pwmL;
	wire  [15:0] pwmR;
	wire         pwmDreq;

	// Queue model, index 0 is left and 1 is right
	logic [11:0] mSlots [2][3];
	logic  [1:0] mRd [2];
	logic  [1:0] mWr [2];
	logic  [1:0] mCount [2];
	logic        mFull [2];
	logic        mEmpty [2];

	logic [15:0] lfsrState  = 16'd48504;
	int          errorCount = 0;
	int          checkCount = 0;
	event        sampleCheck;

	s32xPwmIf DUT (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.tickEn  (tickEn),
		.va      (va),
		.vdi     (vdi),
		.vdo     (vdo),
		.asN     (asN),
		.lwrN    (lwrN),
		.uwrN    (uwrN),
		.cas0N   (cas0N),
		.dtackN  (dtackN),
		.pwmL    (pwmL),
		.pwmR    (pwmR),
		.pwmDreq (pwmDreq)
	);

	always #4 CLK = ~CLK;

	always @(posedge CLK) begin
		#1;
		tickDiv = tickDiv + 2'd1;
		tickEn  = (tickDiv == 2'd0);   // One clock in four
	end

	function automatic logic [15:0] lfsrNext(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [1:0] ringNext(logic [1:0] p);
		return (p == 2'd2) ? 2'd0 : p + 2'd1;
	endfunction

	function automatic logic [22:0] pageAddr(logic [6:0] off);
		return 23'((24'hA15100 + 24'(off)) >> 1);
	endfunction

	// Reference values from the queue model
	function automatic logic [15:0] expectedSample(logic ch);
		logic [11:0] pw;
		pw = mSlots[ch][mRd[ch]];
		return {pw - 12'h800, 4'h0};
	endfunction

	function automatic logic [15:0] expectedStatus(logic ch);
		return {mFull[ch], mEmpty[ch], 14'h0};
	endfunction

	// TM of zero means the 4-bit timer wraps after 16 cycle ends
	function automatic int expectedDreqs(int ticks, int cycleLen, logic [3:0] tm, logic rtp);
		int period;
		period = cycleLen * ((tm == 4'd0) ? 16 : int'(tm));
		if (!rtp) return 0;
		return ticks / period;
	endfunction

	task automatic checkValue(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		checkCount++;
		if (got !== exp) begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic randomWord(output logic [15:0] w);
		w = '0;
		for (int i = 0; i < 16; i++) begin
			lfsrState = lfsrNext(lfsrState);
			w = {w[14:0], lfsrState[0]};
		end
	endtask

	task automatic modelReset();
		for (int c = 0; c < 2; c++) begin
			for (int s = 0; s < 3; s++) begin
				mSlots[c][s] = '0;
			end
			mRd[c]    = '0;
			mWr[c]    = '0;
			mCount[c] = '0;
			mFull[c]  = 1'b0;
			mEmpty[c] = 1'b1;
		end
	endtask

	task automatic modelPush(input logic ch, input logic [11:0] pw);
		mSlots[ch][mWr[ch]] = pw;   // A full queue is overwritten
		mWr[ch] = ringNext(mWr[ch]);
		if (mCount[ch] == 2'd2) begin
			mFull[ch] = 1'b1;
		end else begin
			mCount[ch] = mCount[ch] + 2'd1;
		end
		mEmpty[ch] = 1'b0;
	endtask

	task automatic modelPop();
		for (int c = 0; c < 2; c++) begin
			mRd[c] = ringNext(mRd[c]);
			if (mCount[c] == 2'd0) begin
				mEmpty[c] = 1'b1;
			end else begin
				mCount[c] = mCount[c] - 2'd1;
			end
			mFull[c] = 1'b0;
		end
	endtask

	task automatic waitDtack(input logic level);
		int clocks;
		clocks = 0;
		while (dtackN !== level && clocks < busLimit) begin
			@(posedge CLK);
			#1;
			clocks++;
		end
		if (dtackN !== level) begin
			$display("DTACK did not go to %b within %0d clocks", level, busLimit);
			errorCount++;
		end
	endtask

	task automatic busWrite(input logic [6:0] off, input logic [15:0] data);
		va   = pageAddr(off);
		vdi  = data;
		asN  = 1'b0;
		lwrN = 1'b0;
		uwrN = 1'b0;
		waitDtack(1'b0);
		asN  = 1'b1;
		lwrN = 1'b1;
		uwrN = 1'b1;
		waitDtack(1'b1);
	endtask

	task automatic busRead(input logic [6:0] off, output logic [15:0] data);
		va    = pageAddr(off);
		asN   = 1'b0;
		cas0N = 1'b0;
		waitDtack(1'b0);
		@(posedge CLK);   // Read register loads one edge after DTACK
		#1;
		data  = vdo;
		asN   = 1'b1;
		cas0N = 1'b1;
		waitDtack(1'b1);
	endtask

	task automatic waitTicks(input int n);
		int seen;
		int clocks;
		seen   = 0;
		clocks = 0;
		while (seen < n && clocks < n * tickLimit) begin
			@(posedge CLK);
			clocks++;
			if (tickEn) seen++;
		end
		#1;
		if (seen < n) begin
			$display("Tick enable stopped before %0d ticks were seen", n);
			errorCount++;
		end
	endtask

	task automatic writeWidth(input logic [6:0] off, input logic toLeft, input logic toRight);
		logic [15:0] data;
		randomWord(data);
		busWrite(off, data);
		waitTicks(2);   // Pending push lands on a tick
		if (toLeft) modelPush(1'b0, data[11:0]);
		if (toRight) modelPush(1'b1, data[11:0]);
		-> sampleCheck;
	endtask

	task automatic waitSampleStep(input logic [15:0] lastL, input logic [15:0] lastR);
		int clocks;
		clocks = 0;
		while (pwmL === lastL && pwmR === lastR && clocks < 8 * tickLimit) begin
			@(posedge CLK);
			#1;
			clocks++;
		end
		if (pwmL === lastL && pwmR === lastR) begin
			$display("Samples never stepped after the PWM was started");
			errorCount++;
		end
	endtask

	task automatic countDreqs(input int ticks, output int pulses);
		int   seen;
		int   clocks;
		logic prev;
		seen   = 0;
		clocks = 0;
		pulses = 0;
		prev   = pwmDreq;
		while (seen < ticks && clocks < ticks * tickLimit) begin
			@(posedge CLK);
			clocks++;
			if (tickEn) seen++;
			if (pwmDreq && !prev) pulses++;
			prev = pwmDreq;
		end
		#1;
		if (seen < ticks) begin
			$display("Tick enable stopped while counting DMA requests");
			errorCount++;
		end
	endtask

	always @(sampleCheck) begin
		checkValue("pwmL", pwmL, expectedSample(1'b0));
		checkValue("pwmR", pwmR, expectedSample(1'b1));
	end

	initial begin
		#200000;
		$display("Simulation ran past its time limit");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		logic [15:0] rd;
		logic [15:0] lastL;
		logic [15:0] lastR;
		int          pulses;
		modelReset();
		repeat (2) @(posedge CLK);
		#1;
		RST_N = 1'b1;
		@(posedge CLK);
		#1;

		checkValue("dtackN", 16'(dtackN), 16'h0001);
		checkValue("pwmDreq", 16'(pwmDreq), 16'h0000);
		-> sampleCheck;
		busRead(7'h34, rd);
		checkValue("vdo leftStatus", rd, expectedStatus(1'b0));
		busRead(7'h36, rd);
		checkValue("vdo rightStatus", rd, expectedStatus(1'b1));
		busRead(7'h38, rd);
		checkValue("vdo monoStatus", rd, expectedStatus(1'b0));

		// High byte of PWMCR is out of reach of the 68000
		busWrite(7'h30, 16'hFFFF);
		busRead(7'h30, rd);
		checkValue("vdo pwmCtrl", rd, 16'h008F);
		busWrite(7'h32, 16'hFFFF);
		busRead(7'h32, rd);
		checkValue("vdo cycle", rd, 16'h0FFF);
		busWrite(7'h30, 16'h0000);
		busRead(7'h30, rd);
		checkValue("vdo pwmCtrl", rd, 16'h0000);
		busRead(7'h00, rd);
		checkValue("vdo offset 00", rd, 16'h0000);
		busRead(7'h20, rd);
		checkValue("vdo offset 20", rd, 16'h0000);
		busRead(7'h3A, rd);
		checkValue("vdo offset 3A", rd, 16'h0000);
		busWrite(7'h3C, 16'hFFFF);
		busRead(7'h3C, rd);
		checkValue("vdo offset 3C", rd, 16'h0000);
		busRead(7'h32, rd);
		checkValue("vdo cycle", rd, 16'h0FFF);

		// Upper half of the page holds no registers
		busRead(7'h72, rd);
		checkValue("vdo offset 72", rd, 16'h0000);
		busWrite(7'h70, 16'h0085);
		busRead(7'h70, rd);
		checkValue("vdo offset 70", rd, 16'h0000);
		busRead(7'h30, rd);
		checkValue("vdo pwmCtrl", rd, 16'h0000);

		// Widths with the PWM stopped
		writeWidth(7'h34, 1'b1, 1'b0);
		writeWidth(7'h36, 1'b0, 1'b1);
		writeWidth(7'h38, 1'b1, 1'b1);

		// Over-fill both queues, left first so the two channels differ
		writeWidth(7'h34, 1'b1, 1'b0);
		writeWidth(7'h34, 1'b1, 1'b0);
		busRead(7'h38, rd);
		checkValue("vdo monoStatus", rd, expectedStatus(1'b0));
		busRead(7'h36, rd);
		checkValue("vdo rightStatus", rd, expectedStatus(1'b1));
		writeWidth(7'h36, 1'b0, 1'b1);
		writeWidth(7'h36, 1'b0, 1'b1);
		busRead(7'h34, rd);
		checkValue("vdo leftStatus", rd, expectedStatus(1'b0));
		busRead(7'h36, rd);
		checkValue("vdo rightStatus", rd, expectedStatus(1'b1));
		busRead(7'h38, rd);
		checkValue("vdo monoStatus", rd, expectedStatus(1'b0));

		busWrite(7'h32, 16'(pwmCycle));
		lastL = pwmL;
		lastR = pwmR;
		busWrite(7'h30, 16'h0005);   // Both channels on
		waitSampleStep(lastL, lastR);
		modelPop();
		-> sampleCheck;
		repeat (4) begin
			waitTicks(pwmCycle);
			modelPop();
			-> sampleCheck;
		end
		busWrite(7'h30, 16'h0000);
		-> sampleCheck;
		busRead(7'h34, rd);
		checkValue("vdo leftStatus", rd, expectedStatus(1'b0));
		busRead(7'h36, rd);
		checkValue("vdo rightStatus", rd, expectedStatus(1'b1));

		// DMA requests, TM stays zero
		busWrite(7'h32, 16'd2);
		busWrite(7'h30, 16'h0085);
		countDreqs(dreqTicks, pulses);
		checkValue("pwmDreq pulses", 16'(pulses),
			16'(expectedDreqs(dreqTicks, 2, 4'd0, 1'b1)));
		busWrite(7'h30, 16'h0005);
		countDreqs(dreqTicks, pulses);
		checkValue("pwmDreq pulses", 16'(pulses),
			16'(expectedDreqs(dreqTicks, 2, 4'd0, 1'b0)));
		busWrite(7'h30, 16'h0000);

		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire
